/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = decodeExecuteTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_TEXT = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/decodeExecuteTb.sv */
`timescale 1ns/10ps

module decodeExecuteTb;
  import mipsPkg::*;

  typedef struct packed {
    logic                 valid;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] pcPlus4;
    wbPortT               wb;
    logic                 chkData;
    exMemT                exp;
  } entryT;

  localparam memCtrlT mcNone  = '0;
  localparam memCtrlT mcLoad  = '{branch: 1'b0, branchNe: 1'b0, memWrite: 1'b0, memRead: 1'b1};
  localparam memCtrlT mcStore = '{branch: 1'b0, branchNe: 1'b0, memWrite: 1'b1, memRead: 1'b0};
  localparam memCtrlT mcBeq   = '{branch: 1'b1, branchNe: 1'b0, memWrite: 1'b0, memRead: 1'b0};
  localparam memCtrlT mcBne   = '{branch: 1'b1, branchNe: 1'b1, memWrite: 1'b0, memRead: 1'b0};
  localparam wbCtrlT  wbNone  = '0;
  localparam wbCtrlT  wbReg   = '{memToReg: 1'b0, regWrite: 1'b1};
  localparam wbCtrlT  wbLoad  = '{memToReg: 1'b1, regWrite: 1'b1};

  logic   Clk;
  logic   rst;
  fetchT  fetch;
  wbPortT wbPort;
  exMemT  exMem;

  logic [dataWidth-1:0] preload [32];
  logic [dataWidth-1:0] rf [32];
  logic [dataWidth-1:0] pcNext;
  entryT                stim [$];
  int                   curEntry;
  int                   cycles;
  int                   cycleLimit;

  decodeExecute dut (
    .Clk    (Clk),
    .rst    (rst),
    .fetch  (fetch),
    .wbPort (wbPort),
    .exMem  (exMem)
  );

  always #50 Clk = ~Clk;

  always @(posedge Clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] sext16(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic logic [31:0] zext16(input logic [15:0] imm);
    return {16'h0000, imm};
  endfunction

  function automatic logic [31:0] rWord(input int rs, input int rt, input int rd,
                                        input int shamt, input logic [5:0] funct);
    return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
  endfunction

  function automatic logic [31:0] iWord(input logic [5:0] op, input int rs, input int rt,
                                        input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  task automatic pushEntry(input wbPortT wb, input logic valid, input logic [31:0] instr,
                           input logic zeroExt, input memCtrlT mc, input wbCtrlT wc,
                           input logic [31:0] alu, input logic [31:0] wd, input logic taken,
                           input int dest, input logic chkData);
    entryT       e;
    logic [31:0] immExt;
    immExt = zeroExt ? zext16(instr[15:0]) : sext16(instr[15:0]);
    e.valid              = valid;
    e.instr              = instr;
    e.pcPlus4            = pcNext;
    e.wb                 = wb;
    e.chkData            = chkData;
    e.exp.memCtrl        = mc;
    e.exp.wbCtrl         = wc;
    e.exp.aluResult      = alu;
    e.exp.writeData      = wd;
    e.exp.branchTarget   = pcNext + (immExt << 2);
    e.exp.branchTaken    = taken;
    e.exp.destReg        = 5'(dest);
    stim.push_back(e);
    pcNext = pcNext + 32'd4;
  endtask

  task automatic addOp(input logic [31:0] instr, input logic zeroExt, input memCtrlT mc,
                       input wbCtrlT wc, input logic [31:0] alu, input logic [31:0] wd,
                       input int dest);
    pushEntry('0, 1'b1, instr, zeroExt, mc, wc, alu, wd, 1'b0, dest, 1'b1);
  endtask

  task automatic addBranch(input logic [31:0] instr, input memCtrlT mc, input logic taken);
    pushEntry('0, 1'b1, instr, 1'b0, mc, wbNone, '0, '0, taken, 0, 1'b0);
  endtask

  task automatic addBubble(input logic valid, input logic [31:0] instr);
    pushEntry('0, valid, instr, 1'b0, mcNone, wbNone, '0, '0, 1'b0, 0, 1'b0);
  endtask

  task automatic buildTable();
    pcNext = 32'h0040_0004;
    addOp(rWord(1, 2, 3, 0, fnAdd), 1'b0, mcNone, wbReg, rf[1] + rf[2], rf[2], 3);
    addOp(rWord(1, 2, 20, 0, fnAddu), 1'b0, mcNone, wbReg, rf[1] + rf[2], rf[2], 20);
    addOp(rWord(1, 2, 4, 0, fnSub), 1'b0, mcNone, wbReg, rf[1] - rf[2], rf[2], 4);
    addOp(rWord(2, 1, 21, 0, fnSubu), 1'b0, mcNone, wbReg, rf[2] - rf[1], rf[1], 21);
    addOp(rWord(1, 2, 22, 0, fnAnd), 1'b0, mcNone, wbReg, rf[1] & rf[2], rf[2], 22);
    addOp(rWord(1, 2, 23, 0, fnOr), 1'b0, mcNone, wbReg, rf[1] | rf[2], rf[2], 23);
    addOp(rWord(1, 2, 24, 0, fnXor), 1'b0, mcNone, wbReg, rf[1] ^ rf[2], rf[2], 24);
    addOp(rWord(1, 2, 25, 0, fnNor), 1'b0, mcNone, wbReg, ~(rf[1] | rf[2]), rf[2], 25);
    // r5 is negative and r6 is not
    addOp(rWord(5, 6, 26, 0, fnSlt), 1'b0, mcNone, wbReg, 32'd1, rf[6], 26);
    addOp(rWord(6, 5, 27, 0, fnSlt), 1'b0, mcNone, wbReg, 32'd0, rf[5], 27);
    addOp(rWord(1, 2, 0, 0, fnAdd), 1'b0, mcNone, wbReg, rf[1] + rf[2], rf[2], 0);
    // Write-back to $zero in the same cycle must not leak through
    pushEntry('{en: 1'b1, addr: 5'd0, data: 32'hdead_beef}, 1'b1, rWord(0, 1, 7, 0, fnOr),
              1'b0, mcNone, wbReg, rf[1], rf[1], 1'b0, 7, 1'b1);
    addOp(rWord(0, 0, 8, 0, fnAdd), 1'b0, mcNone, wbReg, 32'h0, 32'h0, 8);
    addOp(iWord(opAddi, 1, 9, 16'hfff0), 1'b0, mcNone, wbReg, rf[1] + 32'hffff_fff0, rf[9], 9);
    addOp(iWord(opAddiu, 2, 10, 16'h7ffc), 1'b0, mcNone, wbReg, rf[2] + 32'h7ffc, rf[10], 10);
    addOp(iWord(opSlti, 5, 11, 16'h0005), 1'b0, mcNone, wbReg, 32'd1, rf[11], 11);
    addOp(iWord(opSlti, 6, 12, 16'h8000), 1'b0, mcNone, wbReg, 32'd0, rf[12], 12);
    addOp(iWord(opAndi, 1, 13, 16'hf0f0), 1'b1, mcNone, wbReg, rf[1] & 32'h0000_f0f0, rf[13], 13);
    addOp(iWord(opOri, 2, 14, 16'h8001), 1'b1, mcNone, wbReg, rf[2] | 32'h0000_8001, rf[14], 14);
    addOp(iWord(opXori, 3, 15, 16'hffff), 1'b1, mcNone, wbReg, rf[3] ^ 32'h0000_ffff, rf[15], 15);
    addOp(iWord(opLui, 0, 16, 16'h1234), 1'b0, mcNone, wbReg, 32'h1234_0000, rf[16], 16);
    addOp(rWord(0, 1, 17, 4, fnSll), 1'b0, mcNone, wbReg, {rf[1][27:0], 4'h0}, rf[1], 17);
    addOp(rWord(0, 5, 18, 8, fnSrl), 1'b0, mcNone, wbReg, {8'h00, rf[5][31:8]}, rf[5], 18);
    addOp(rWord(0, 5, 19, 8, fnSra), 1'b0, mcNone, wbReg,
          {{8{rf[5][31]}}, rf[5][31:8]}, rf[5], 19);
    addOp(rWord(0, 6, 28, 4, fnSra), 1'b0, mcNone, wbReg,
          {{4{rf[6][31]}}, rf[6][31:4]}, rf[6], 28);
    addOp(iWord(opLw, 1, 16, 16'h0010), 1'b0, mcLoad, wbLoad, rf[1] + 32'h10, rf[16], 16);
    addOp(iWord(opSw, 2, 17, 16'hfff8), 1'b0, mcStore, wbNone, rf[2] - 32'h8, rf[17], 17);
    addBranch(iWord(opBeq, 3, 3, 16'h0004), mcBeq, 1'b1);
    addBranch(iWord(opBeq, 1, 2, 16'h0010), mcBeq, rf[1] == rf[2]);
    addBranch(iWord(opBne, 1, 2, 16'hfffe), mcBne, rf[1] != rf[2]);
    addBranch(iWord(opBne, 4, 4, 16'h0003), mcBne, 1'b0);
    addBubble(1'b1, iWord(6'h3f, 1, 2, 16'h8004));
    addBubble(1'b1, rWord(1, 2, 3, 0, 6'h3f));
    addBubble(1'b0, rWord(1, 2, 3, 0, fnAdd));
    // rs is written back in the very cycle it is read
    pushEntry('{en: 1'b1, addr: 5'd1, data: 32'h0bad_f00d}, 1'b1, rWord(1, 2, 29, 0, fnAdd),
              1'b0, mcNone, wbReg, 32'h0bad_f00d + rf[2], rf[2], 1'b0, 29, 1'b1);
    rf[1] = 32'h0bad_f00d;
    addOp(rWord(1, 2, 30, 0, fnSub), 1'b0, mcNone, wbReg, rf[1] - rf[2], rf[2], 30);
  endtask

  task automatic reportMismatch(input string field, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("MISMATCH at %0t: entry %0d field %s got %h expected %h",
             $time, curEntry, field, got, exp);
    $display("CHECKS FAILED");
    $fatal(1, "mismatch on %s", field);
  endtask

  task automatic checkData(input exMemT got, input exMemT exp);
    if (got.aluResult !== exp.aluResult) reportMismatch("aluResult", got.aluResult, exp.aluResult);
    if (got.writeData !== exp.writeData) reportMismatch("writeData", got.writeData, exp.writeData);
    if (got.destReg !== exp.destReg) begin
      reportMismatch("destReg", 32'(got.destReg), 32'(exp.destReg));
    end
  endtask

  task automatic checkCtrl(input exMemT got, input exMemT exp);
    if (got.memCtrl.branch !== exp.memCtrl.branch) begin
      reportMismatch("branch", 32'(got.memCtrl.branch), 32'(exp.memCtrl.branch));
    end
    if (got.memCtrl.branchNe !== exp.memCtrl.branchNe) begin
      reportMismatch("branchNe", 32'(got.memCtrl.branchNe), 32'(exp.memCtrl.branchNe));
    end
    if (got.memCtrl.memWrite !== exp.memCtrl.memWrite) begin
      reportMismatch("memWrite", 32'(got.memCtrl.memWrite), 32'(exp.memCtrl.memWrite));
    end
    if (got.memCtrl.memRead !== exp.memCtrl.memRead) begin
      reportMismatch("memRead", 32'(got.memCtrl.memRead), 32'(exp.memCtrl.memRead));
    end
    if (got.wbCtrl.memToReg !== exp.wbCtrl.memToReg) begin
      reportMismatch("memToReg", 32'(got.wbCtrl.memToReg), 32'(exp.wbCtrl.memToReg));
    end
    if (got.wbCtrl.regWrite !== exp.wbCtrl.regWrite) begin
      reportMismatch("regWrite", 32'(got.wbCtrl.regWrite), 32'(exp.wbCtrl.regWrite));
    end
    if (got.branchTaken !== exp.branchTaken) begin
      reportMismatch("branchTaken", 32'(got.branchTaken), 32'(exp.branchTaken));
    end
    if (got.branchTarget !== exp.branchTarget) begin
      reportMismatch("branchTarget", got.branchTarget, exp.branchTarget);
    end
  endtask

  initial begin
    Clk      = 1'b0;
    rst      = 1'b1;
    fetch    = '0;
    wbPort   = '0;
    cycles   = 0;
    curEntry = -1;
    void'($urandom(72671));
    preload[0] = '0;
    for (int i = 1; i < 32; i++) begin
      preload[i] = $urandom();
    end
    // Known signs for the slt and sra cases
    preload[5] = preload[5] | 32'h8000_0000;
    preload[6] = preload[6] & 32'h7fff_ffff;
    rf = preload;
    buildTable();
    cycleLimit = 8 + 31 + stim.size() + 10;

    repeat (8) @(negedge Clk);
    rst = 1'b0;
    checkCtrl(exMem, '0);

    for (int i = 1; i < 32; i++) begin
      wbPort = '{en: 1'b1, addr: 5'(i), data: preload[i]};
      @(negedge Clk);
    end

    // Entry k is checked two edges after it is applied
    for (int k = 0; k < stim.size() + 2; k++) begin
      if (k >= 2) begin
        curEntry = k - 2;
        checkCtrl(exMem, stim[k-2].exp);
        if (stim[k-2].chkData) begin
          checkData(exMem, stim[k-2].exp);
        end
      end
      if (k < stim.size()) begin
        fetch  = '{valid: stim[k].valid, instr: stim[k].instr, pcPlus4: stim[k].pcPlus4};
        wbPort = stim[k].wb;
      end else begin
        fetch  = '0;
        wbPort = '0;
      end
      @(negedge Clk);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* verilog/aluExecute.sv */
`timescale 1ns/10ps

module aluExecute (
  input  mipsPkg::idExT  idEx,
  output mipsPkg::exMemT exMem
);
  import mipsPkg::*;

  logic [dataWidth-1:0]  opA;
  logic [dataWidth-1:0]  opB;
  logic [shamtWidth-1:0] shiftAmt;
  logic [dataWidth-1:0]  aluResult;
  logic                  lessThan;
  logic                  operandsEqual;
  logic                  branchTaken;

  assign opA = idEx.readData1;
  assign opB = idEx.exCtrl.aluSrc ? idEx.immExt : idEx.readData2;

  // Fallback to rs low bits covers variable shifts
  assign shiftAmt = idEx.exCtrl.useShamt ? idEx.shamt : idEx.readData1[shamtWidth-1:0];

  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    case (idEx.exCtrl.aluOp)
      aluAdd: aluResult = opA + opB;
      aluSub: aluResult = opA - opB;
      aluAnd: aluResult = opA & opB;
      aluOr:  aluResult = opA | opB;
      aluXor: aluResult = opA ^ opB;
      aluNor: aluResult = ~(opA | opB);
      aluSlt: aluResult = {{(dataWidth-1){1'b0}}, lessThan};
      // Shifts act on rt
      aluSll: aluResult = idEx.readData2 << shiftAmt;
      aluSrl: aluResult = idEx.readData2 >> shiftAmt;
      aluSra: aluResult = $signed(idEx.readData2) >>> shiftAmt;
      aluLui: aluResult = {opB[immWidth-1:0], {(dataWidth-immWidth){1'b0}}};
      default: aluResult = '0;
    endcase
  end

  assign operandsEqual = (idEx.readData1 == idEx.readData2);

  always_comb begin
    branchTaken = 1'b0;
    if (idEx.memCtrl.branch) begin
      if (idEx.memCtrl.branchNe) begin
        branchTaken = !operandsEqual;
      end else begin
        branchTaken = operandsEqual;
      end
    end
  end

  always_comb begin
    exMem.memCtrl      = idEx.memCtrl;
    exMem.wbCtrl       = idEx.wbCtrl;
    exMem.aluResult    = aluResult;
    exMem.writeData    = idEx.readData2;
    // Word offset relative to the delay slot
    exMem.branchTarget = idEx.pcPlus4 + (idEx.immExt << 2);
    exMem.branchTaken  = branchTaken;
    exMem.destReg      = idEx.exCtrl.regDst ? idEx.rdDest : idEx.rtDest;
  end

endmodule

/* verilog/decodeExecute.sv */
`timescale 1ns/10ps

module decodeExecute (
  input  logic             Clk,
  input  logic             rst,
  input  mipsPkg::fetchT   fetch,
  input  mipsPkg::wbPortT  wbPort,
  output mipsPkg::exMemT   exMem
);
  import mipsPkg::*;

  exCtrlT                  exCtrl;
  memCtrlT                 memCtrl;
  wbCtrlT                  wbCtrl;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    readData1;
  logic [dataWidth-1:0]    readData2;
  logic [regAddrWidth-1:0] rsAddr;
  logic [regAddrWidth-1:0] rtAddr;
  logic [regAddrWidth-1:0] rdAddr;
  logic [shamtWidth-1:0]   shamt;
  idExT                    idExD;
  idExT                    idExQ;
  exMemT                   exMemD;

  // Register fields of the instruction word
  assign rsAddr = fetch.instr[25:21];
  assign rtAddr = fetch.instr[20:16];
  assign rdAddr = fetch.instr[15:11];
  assign shamt  = fetch.instr[10:6];

  instrDecode decode (
    .fetch   (fetch),
    .exCtrl  (exCtrl),
    .memCtrl (memCtrl),
    .wbCtrl  (wbCtrl),
    .immExt  (immExt)
  );

  regFile regs (
    .Clk       (Clk),
    .rst       (rst),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .wbPort    (wbPort),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  assign idExD = '{exCtrl: exCtrl, memCtrl: memCtrl, wbCtrl: wbCtrl,
                   readData1: readData1, readData2: readData2,
                   pcPlus4: fetch.pcPlus4, immExt: immExt,
                   rtDest: rtAddr, rdDest: rdAddr, shamt: shamt};

  pipeStage #(.payloadT(idExT)) idExStage (
    .Clk (Clk),
    .rst (rst),
    .d   (idExD),
    .q   (idExQ)
  );

  aluExecute execute (
    .idEx  (idExQ),
    .exMem (exMemD)
  );

  pipeStage #(.payloadT(exMemT)) exMemStage (
    .Clk (Clk),
    .rst (rst),
    .d   (exMemD),
    .q   (exMem)
  );

endmodule

/* verilog/instrDecode.sv */
`timescale 1ns/10ps

module instrDecode (
  input  mipsPkg::fetchT                 fetch,
  output mipsPkg::exCtrlT                exCtrl,
  output mipsPkg::memCtrlT               memCtrl,
  output mipsPkg::wbCtrlT                wbCtrl,
  output logic [mipsPkg::dataWidth-1:0]  immExt
);
  import mipsPkg::*;

  logic [5:0]          opcode;
  logic [5:0]          funct;
  logic [immWidth-1:0] imm;
  logic                zeroExt;

  assign opcode = fetch.instr[31:26];
  assign funct  = fetch.instr[5:0];
  assign imm    = fetch.instr[immWidth-1:0];

  // Logical immediates are unsigned
  assign zeroExt = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
  assign immExt  = zeroExt ? {{(dataWidth-immWidth){1'b0}}, imm}
                           : {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};

  always_comb begin
    exCtrl  = '0;
    memCtrl = '0;
    wbCtrl  = '0;
    if (fetch.valid) begin
      case (opcode)
        opRType: begin
          exCtrl.regDst   = 1'b1;
          wbCtrl.regWrite = 1'b1;
          case (funct)
            fnAdd, fnAddu: exCtrl.aluOp = aluAdd;
            fnSub, fnSubu: exCtrl.aluOp = aluSub;
            fnAnd:         exCtrl.aluOp = aluAnd;
            fnOr:          exCtrl.aluOp = aluOr;
            fnXor:         exCtrl.aluOp = aluXor;
            fnNor:         exCtrl.aluOp = aluNor;
            fnSlt:         exCtrl.aluOp = aluSlt;
            fnSll, fnSrl, fnSra: begin
              exCtrl.useShamt = 1'b1;
              if (funct == fnSll) begin
                exCtrl.aluOp = aluSll;
              end else if (funct == fnSrl) begin
                exCtrl.aluOp = aluSrl;
              end else begin
                exCtrl.aluOp = aluSra;
              end
            end
            default: begin
              // Unsupported funct becomes a bubble
              exCtrl = '0;
              wbCtrl = '0;
            end
          endcase
        end
        opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
          exCtrl.aluSrc   = 1'b1;
          wbCtrl.regWrite = 1'b1;
          case (opcode)
            opSlti:  exCtrl.aluOp = aluSlt;
            opAndi:  exCtrl.aluOp = aluAnd;
            opOri:   exCtrl.aluOp = aluOr;
            opXori:  exCtrl.aluOp = aluXor;
            opLui:   exCtrl.aluOp = aluLui;
            default: exCtrl.aluOp = aluAdd;
          endcase
        end
        opLw: begin
          exCtrl.aluSrc   = 1'b1;
          memCtrl.memRead = 1'b1;
          wbCtrl.memToReg = 1'b1;
          wbCtrl.regWrite = 1'b1;
        end
        opSw: begin
          exCtrl.aluSrc    = 1'b1;
          memCtrl.memWrite = 1'b1;
        end
        opBeq, opBne: begin
          exCtrl.aluOp     = aluSub;
          memCtrl.branch   = 1'b1;
          memCtrl.branchNe = (opcode == opBne);
        end
        default: begin
          exCtrl  = '0;
          memCtrl = '0;
          wbCtrl  = '0;
        end
      endcase
    end
  end

endmodule

/* verilog/mipsPkg.sv */
package mipsPkg;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int shamtWidth   = 5;
  localparam int immWidth     = 16;

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opBne   = 6'h05;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opAddiu = 6'h09;
  localparam logic [5:0] opSlti  = 6'h0a;
  localparam logic [5:0] opAndi  = 6'h0c;
  localparam logic [5:0] opOri   = 6'h0d;
  localparam logic [5:0] opXori  = 6'h0e;
  localparam logic [5:0] opLui   = 6'h0f;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  // R-type funct codes, instr[5:0]
  localparam logic [5:0] fnSll  = 6'h00;
  localparam logic [5:0] fnSrl  = 6'h02;
  localparam logic [5:0] fnSra  = 6'h03;
  localparam logic [5:0] fnAdd  = 6'h20;
  localparam logic [5:0] fnAddu = 6'h21;
  localparam logic [5:0] fnSub  = 6'h22;
  localparam logic [5:0] fnSubu = 6'h23;
  localparam logic [5:0] fnAnd  = 6'h24;
  localparam logic [5:0] fnOr   = 6'h25;
  localparam logic [5:0] fnXor  = 6'h26;
  localparam logic [5:0] fnNor  = 6'h27;
  localparam logic [5:0] fnSlt  = 6'h2a;

  // Zero encodes add, so a bubble is a harmless add
  typedef enum logic [5:0] {
    aluAdd = 6'd0,
    aluSub = 6'd1,
    aluAnd = 6'd2,
    aluOr  = 6'd3,
    aluXor = 6'd4,
    aluNor = 6'd5,
    aluSlt = 6'd6,
    aluSll = 6'd7,
    aluSrl = 6'd8,
    aluSra = 6'd9,
    aluLui = 6'd10
  } aluOpT;

  typedef struct packed {
    logic  aluSrc;
    aluOpT aluOp;
    logic  regDst;
    logic  useShamt;
  } exCtrlT;

  typedef struct packed {
    logic branch;
    logic branchNe;
    logic memWrite;
    logic memRead;
  } memCtrlT;

  typedef struct packed {
    logic memToReg;
    logic regWrite;
  } wbCtrlT;

  typedef struct packed {
    exCtrlT                  exCtrl;
    memCtrlT                 memCtrl;
    wbCtrlT                  wbCtrl;
    logic [dataWidth-1:0]    readData1;
    logic [dataWidth-1:0]    readData2;
    logic [dataWidth-1:0]    pcPlus4;
    logic [dataWidth-1:0]    immExt;
    logic [regAddrWidth-1:0] rtDest;
    logic [regAddrWidth-1:0] rdDest;
    logic [shamtWidth-1:0]   shamt;
  } idExT;

  typedef struct packed {
    memCtrlT                 memCtrl;
    wbCtrlT                  wbCtrl;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    writeData;
    logic [dataWidth-1:0]    branchTarget;
    logic                    branchTaken;
    logic [regAddrWidth-1:0] destReg;
  } exMemT;

  typedef struct packed {
    logic                 valid;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] pcPlus4;
  } fetchT;

  typedef struct packed {
    logic                    en;
    logic [regAddrWidth-1:0] addr;
    logic [dataWidth-1:0]    data;
  } wbPortT;

endpackage

/* verilog/pipeStage.sv */
`timescale 1ns/10ps

module pipeStage #(
  parameter type payloadT = logic
) (
  input  logic    Clk,
  input  logic    rst,
  input  payloadT d,
  output payloadT q
);

  // Whole payload clears so every control reads inactive after reset
  always_ff @(posedge Clk) begin
    if (rst) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/10ps

module regFile (
  input  logic                             Clk,
  input  logic                             rst,
  input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
  input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
  input  mipsPkg::wbPortT                  wbPort,
  output logic [mipsPkg::dataWidth-1:0]    readData1,
  output logic [mipsPkg::dataWidth-1:0]    readData2
);
  import mipsPkg::*;

  logic [dataWidth-1:0] regs [2**regAddrWidth];
  logic                 wrLive;

  // $zero is never written
  assign wrLive = wbPort.en && (wbPort.addr != '0);

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wbPort.addr] <= wbPort.data;
    end
  end

  // Same-cycle write data wins over the stored value
  always_comb begin
    if (rsAddr == '0) begin
      readData1 = '0;
    end else if (wrLive && (wbPort.addr == rsAddr)) begin
      readData1 = wbPort.data;
    end else begin
      readData1 = regs[rsAddr];
    end
    if (rtAddr == '0) begin
      readData2 = '0;
    end else if (wrLive && (wbPort.addr == rtAddr)) begin
      readData2 = wbPort.data;
    end else begin
      readData2 = regs[rtAddr];
    end
  end

endmodule

/* vlog.f */
verilog/mipsPkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/pipeStage.sv
verilog/aluExecute.sv
verilog/decodeExecute.sv
tb/decodeExecuteTb.sv
